/* tb.f */
src/screenPkg.sv
src/gamePkg.sv
src/tileMap.sv
src/tankMotion.sv
src/tankSprite.sv
src/pixelShader.sv
src/tankArena.sv
verif/tankArena_checker.sv
verif/tankArenaTb.sv

/* verif/tankArenaTb.sv */
`timescale 1ns/1ps

module tankArenaTb;

    localparam int pixelsPerFrame = 24;
    localparam int holdFrames = 8;
    localparam int minFrames = 300;
    localparam int maxFrames = 4000;
    // Every frame at full length plus reset and flush margin
    localparam int watchLimitNs = maxFrames * (pixelsPerFrame + 2) * 8 + 2000;

    logic Master_Clock_In;
    logic rstN;
    logic displayEnable;
    screenPkg::screenPos pixelPos;
    gamePkg::padButtons buttons;
    gamePkg::padButtons nextButtons;
    gamePkg::rgbColour pixelColour;
    screenPkg::screenPos tankPos;

    // Reference model state
    screenPkg::screenPos expPos;
    gamePkg::tankFacing expFacing;
    gamePkg::tankFacing pendFacing;
    screenPkg::screenPos expNextPos;
    logic nextWraps;
    logic nextPushes;
    int wrapCount;
    int pushCount;
    integer seed;

    // Expected colour and the case it falls in
    gamePkg::rgbColour expColour;
    logic expBlank;
    logic expOutside;
    logic expSprite;
    logic expTile;
    logic expFrameEnd;

    tankArena UUT (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .displayEnable   (displayEnable),
        .pixelPos        (pixelPos),
        .buttons         (buttons),
        .pixelColour     (pixelColour),
        .tankPos         (tankPos)
    );

    bind tankArena tankArenaChecker checks (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .pixelColour     (pixelColour),
        .tankPos         (tankPos),
        .facing          (sprite.facing),
        .expColour       (tankArenaTb.expColour),
        .expBlank        (tankArenaTb.expBlank),
        .expOutside      (tankArenaTb.expOutside),
        .expSprite       (tankArenaTb.expSprite),
        .expTile         (tankArenaTb.expTile),
        .expFrameEnd     (tankArenaTb.expFrameEnd),
        .expNextPos      (tankArenaTb.expNextPos),
        .expPos          (tankArenaTb.expPos),
        .expFacing       (tankArenaTb.expFacing)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Tiles are 32 pixels and the grid index wraps
    // Column 0 sits in the top nibble
    function automatic gamePkg::tileCode mapTile(input int x, input int y);
        int col;
        int row;
        col = (x / 32) % screenPkg::tileCols;
        row = (y / 32) % screenPkg::tileRows;
        return gamePkg::mapRows[row][(79 - 4 * col) -: 4];
    endfunction

    // Walls and bricks
    function automatic logic blocks(input gamePkg::tileCode code);
        return (code == 4'd1) || (code == 4'd2);
    endfunction

    function automatic gamePkg::rgbColour paletteOf(input gamePkg::tileCode code);
        if (code == 4'd0)
            return gamePkg::colourOpen;
        else if ((code == 4'd1) || (code == 4'd2))
            return gamePkg::colourBrick;
        else if (code == 4'd3)
            return gamePkg::colourGrass;
        else if ((code >= 4'd4) && (code <= 4'd7))
            return gamePkg::colourHazard;
        return gamePkg::colourUnknown;
    endfunction

    // Barrel strip spans 11..14 across and the front 13 rows along the facing
    function automatic gamePkg::rgbColour spriteOf(input int dx, input int dy,
            input gamePkg::tankFacing face);
        int u;
        int v;
        u = (face == gamePkg::faceLeft || face == gamePkg::faceRight) ? dy : dx;
        case (face)
            gamePkg::faceDown:
                v = 25 - dy;
            gamePkg::faceLeft:
                v = dx;
            gamePkg::faceRight:
                v = 25 - dx;
            default:
                v = dy;
        endcase
        if ((u >= 11) && (u <= 14) && (v <= 12))
            return gamePkg::colourBarrel;
        return gamePkg::colourBody;
    endfunction

    // Frame end result of wrap, then pushback, then buttons
    task automatic predictMotion();
        int x;
        int y;
        int edgeX;
        int edgeY;
        logic tl;
        logic tr;
        logic bl;
        logic br;
        edgeX = screenPkg::pixelsHoriz - gamePkg::tankWidth;
        edgeY = screenPkg::pixelsVert - gamePkg::tankWidth;
        x = expPos.x;
        y = expPos.y;
        nextWraps = (y == 0) || (y == edgeY) || (x == 0) || (x == edgeX);
        if ((y == 0) || (y == edgeY))
            y = (y == 0) ? edgeY - 1 : 1;
        if ((x == 0) || (x == edgeX))
            x = (x == 0) ? edgeX - 1 : 1;
        tl = blocks(mapTile(x, y));
        tr = blocks(mapTile(x + 25, y));
        bl = blocks(mapTile(x, y + 25));
        br = blocks(mapTile(x + 25, y + 25));
        nextPushes = tl || tr || bl || br;
        if (bl && br)
            y = y - 1;
        else if (tl && bl)
            x = x + 1;
        else if (tl && tr)
            y = y + 1;
        else if (tr && br)
            x = x - 1;
        else if (tl || tr)
        begin
            y = y + 1;
            x = tl ? x + 1 : x - 1;
        end
        else if (bl || br)
        begin
            y = y - 1;
            x = bl ? x + 1 : x - 1;
        end
        else if (buttons.up)
            y = y - 1;
        else if (buttons.right)
            x = x + 1;
        else if (buttons.down)
            y = y + 1;
        else if (buttons.left)
            x = x - 1;
        expNextPos.x = screenPkg::coordWidth'(x);
        expNextPos.y = screenPkg::coordWidth'(y);
    endtask

    // Expected results for the inputs now on the DUT
    task automatic predict();
        int px;
        int py;
        int tx;
        int ty;
        logic inBox;
        px = pixelPos.x;
        py = pixelPos.y;
        tx = expPos.x;
        ty = expPos.y;
        inBox = (px >= tx) && (px <= tx + 25) && (py >= ty) && (py <= ty + 25);
        expBlank = !displayEnable;
        expOutside = displayEnable && ((px > 640) || (py > 480));
        expSprite = displayEnable && !expOutside && inBox;
        expTile = displayEnable && !expOutside && !inBox;
        if (expBlank)
            expColour = gamePkg::colourBlank;
        else if (expOutside)
            expColour = gamePkg::colourOutside;
        else if (inBox)
            expColour = spriteOf(px - tx, py - ty, expFacing);
        else
            expColour = paletteOf(mapTile(px, py));
        expFrameEnd = displayEnable && (px == 640) && (py == 480);
        // Facing priority up, down, left, right
        if (buttons.up)
            pendFacing = gamePkg::faceUp;
        else if (buttons.down)
            pendFacing = gamePkg::faceDown;
        else if (buttons.left)
            pendFacing = gamePkg::faceLeft;
        else if (buttons.right)
            pendFacing = gamePkg::faceRight;
        else
            pendFacing = expFacing;
        predictMotion();
    endtask

    // One pixel per clock
    // Model registers move on the same edge
    task automatic stepPixel(input int x, input int y, input logic en);
        @(posedge Master_Clock_In);
        if (expFrameEnd)
        begin
            expPos = expNextPos;
            wrapCount += nextWraps;
            pushCount += nextPushes;
        end
        expFacing = pendFacing;
        #1;
        displayEnable = en;
        pixelPos.x = screenPkg::coordWidth'(x);
        pixelPos.y = screenPkg::coordWidth'(y);
        buttons = nextButtons;
        predict();
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, stimulus, watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin
        Master_Clock_In = 1'b0;
        forever
            #4 Master_Clock_In = ~Master_Clock_In;
    end

    initial
    begin
        int frame;
        int r;
        int x;
        int y;
        seed = 32'hc1f5;
        rstN = 1'b0;
        displayEnable = 1'b0;
        pixelPos = '0;
        buttons = '0;
        nextButtons = '0;
        expPos = gamePkg::tankStart;
        expFacing = gamePkg::faceUp;
        wrapCount = 0;
        pushCount = 0;
        predict();
        repeat (2) @(posedge Master_Clock_In);
        #1 rstN = 1'b1;

        // Keep going until both pushback and wrap were seen
        frame = 0;
        while ((frame < minFrames)
                || (((wrapCount == 0) || (pushCount == 0)) && (frame < maxFrames)))
        begin
            // Direction held for several frames, mostly right and then down
            if (frame % holdFrames == 0)
            begin
                r = $unsigned($random(seed)) % 20;
                nextButtons = '0;
                if (r < 9)
                    nextButtons.right = 1'b1;
                else if (r < 14)
                    nextButtons.down = 1'b1;
                else if (r < 17)
                    nextButtons.up = 1'b1;
                else if (r < 19)
                    nextButtons.left = 1'b1;
            end
            // Frame end point with the display off leaves the tank in place
            stepPixel(640, 480, 1'b0);
            for (int i = 1; i < pixelsPerFrame; i++)
            begin
                r = $unsigned($random(seed)) % 8;
                if (r < 3)
                begin
                    // Inside the tank box
                    x = expPos.x + $unsigned($random(seed)) % 26;
                    y = expPos.y + $unsigned($random(seed)) % 26;
                end
                else if (r == 3)
                begin
                    // Right of the active area
                    x = 641 + $unsigned($random(seed)) % 383;
                    y = $unsigned($random(seed)) % 1024;
                end
                else if (r == 4)
                begin
                    // Below the active area
                    x = $unsigned($random(seed)) % 641;
                    y = 481 + $unsigned($random(seed)) % 543;
                end
                else
                begin
                    x = $unsigned($random(seed)) % 641;
                    y = $unsigned($random(seed)) % 481;
                end
                stepPixel(x, y, ($unsigned($random(seed)) % 8) != 0);
            end
            stepPixel(640, 480, 1'b1);
            frame++;
        end

        // Let the last checks complete
        stepPixel(0, 0, 1'b0);
        stepPixel(0, 0, 1'b0);
        @(posedge Master_Clock_In);
        #1;
        if ((UUT.checks.failCount != 0) || (wrapCount == 0) || (pushCount == 0))
        begin
            $display("Test failed");
            $fatal(1, "run ended with %0d wraps, %0d pushbacks, %0d failed checks",
                wrapCount, pushCount, UUT.checks.failCount);
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

    // First failed assertion ends the run
    initial
    begin
        wait (UUT.checks.failCount != 0);
        $display("Test failed");
        $fatal(1, "a checker assertion failed");
    end

    initial
    begin
        #(watchLimitNs);
        $display("Test failed");
        $fatal(1, "watchdog expired before the run finished");
    end

endmodule

/* verif/tankArena_checker.sv */
`timescale 1ns/1ps

module tankArenaChecker (
    input  logic                  Master_Clock_In,
    input  logic                  rstN,
    input  gamePkg::rgbColour     pixelColour,
    input  screenPkg::screenPos   tankPos,
    input  gamePkg::tankFacing    facing,
    input  gamePkg::rgbColour     expColour,
    input  logic                  expBlank,
    input  logic                  expOutside,
    input  logic                  expSprite,
    input  logic                  expTile,
    input  logic                  expFrameEnd,
    input  screenPkg::screenPos   expNextPos,
    input  screenPkg::screenPos   expPos,
    input  gamePkg::tankFacing    expFacing
);

    // Count of failed assertions, watched by the testbench
    int failCount = 0;

    ////////////////////////////////////////////////////////////
    // Reset state
    ////////////////////////////////////////////////////////////

    resetState: assert property (@(posedge Master_Clock_In)
        !rstN |=> (pixelColour == gamePkg::colourBlank) && (tankPos == gamePkg::tankStart))
    else
    begin
        $error("error at %0t: reset state wrong, colour %h tank %h", $time, pixelColour,
            tankPos);
        failCount++;
    end

    ////////////////////////////////////////////////////////////
    // Colour output, one cycle after the pixel
    ////////////////////////////////////////////////////////////

    blankColour: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        expBlank |=> pixelColour == $past(expColour))
    else
    begin
        $error("error at %0t: blanked pixel gave colour %h", $time, pixelColour);
        failCount++;
    end

    // Beyond 640 or 480
    outsideColour: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        expOutside |=> pixelColour == $past(expColour))
    else
    begin
        $error("error at %0t: outside pixel gave colour %h", $time, pixelColour);
        failCount++;
    end

    // Barrel or body, follows the facing
    spriteColour: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        expSprite |=> pixelColour == $past(expColour))
    else
    begin
        $error("error at %0t: tank pixel gave colour %h", $time, pixelColour);
        failCount++;
    end

    tileColour: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        expTile |=> pixelColour == $past(expColour))
    else
    begin
        $error("error at %0t: map pixel gave colour %h", $time, pixelColour);
        failCount++;
    end

    ////////////////////////////////////////////////////////////
    // Tank position and facing
    ////////////////////////////////////////////////////////////

    // Held between frame end strobes
    tankHeld: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        !expFrameEnd |=> $stable(tankPos))
    else
    begin
        $error("error at %0t: tank moved without a frame end, now %h", $time, tankPos);
        failCount++;
    end

    // Wrap, pushback, then button move
    tankStep: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        expFrameEnd |=> tankPos == $past(expNextPos))
    else
    begin
        $error("error at %0t: frame end update gave tank %h", $time, tankPos);
        failCount++;
    end

    tankTrack: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        tankPos == expPos)
    else
    begin
        $error("error at %0t: tank %h, model holds %h", $time, tankPos, expPos);
        failCount++;
    end

    facingTrack: assert property (@(posedge Master_Clock_In) disable iff (!rstN)
        facing == expFacing)
    else
    begin
        $error("error at %0t: facing %0d, model holds %0d", $time, facing, expFacing);
        failCount++;
    end

endmodule

/* src/tankArena.sv */
`timescale 1ns/1ps

module tankArena (
    input  logic                  Master_Clock_In,
    input  logic                  rstN,
    input  logic                  displayEnable,
    input  screenPkg::screenPos   pixelPos,
    input  gamePkg::padButtons    buttons,
    output gamePkg::rgbColour     pixelColour,
    output screenPkg::screenPos   tankPos
);

    gamePkg::tileCode pixelTile;
    gamePkg::cornerTiles corners;
    logic inTank;
    gamePkg::rgbColour spriteColour;

    ////////////////////////////////////////////////////////////
    // Map lookup and tank motion
    ////////////////////////////////////////////////////////////

    tileMap lookup (
        .pixelPos   (pixelPos),
        .tankPos    (tankPos),
        .pixelTile  (pixelTile),
        .corners    (corners)
    );

    tankMotion motion (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .displayEnable   (displayEnable),
        .pixelPos        (pixelPos),
        .buttons         (buttons),
        .corners         (corners),
        .tankPos         (tankPos)
    );

    ////////////////////////////////////////////////////////////
    // Sprite and colour output
    ////////////////////////////////////////////////////////////

    tankSprite sprite (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .pixelPos        (pixelPos),
        .tankPos         (tankPos),
        .buttons         (buttons),
        .inTank          (inTank),
        .spriteColour    (spriteColour)
    );

    pixelShader shader (
        .Master_Clock_In (Master_Clock_In),
        .rstN            (rstN),
        .displayEnable   (displayEnable),
        .pixelPos        (pixelPos),
        .pixelTile       (pixelTile),
        .inTank          (inTank),
        .spriteColour    (spriteColour),
        .pixelColour     (pixelColour)
    );

endmodule

/* src/pixelShader.sv */
`timescale 1ns/1ps

module pixelShader (
    input  logic                  Master_Clock_In,
    input  logic                  rstN,
    input  logic                  displayEnable,
    input  screenPkg::screenPos   pixelPos,
    input  gamePkg::tileCode      pixelTile,
    input  logic                  inTank,
    input  gamePkg::rgbColour     spriteColour,
    output gamePkg::rgbColour     pixelColour
);

    // Flat palette per tile type
    function automatic gamePkg::rgbColour tileColour(input gamePkg::tileCode code);
        case (code) inside
            gamePkg::tileOpen:
                return gamePkg::colourOpen;
            gamePkg::tileWall, gamePkg::tileBrick:
                return gamePkg::colourBrick;
            gamePkg::tileGrass:
                return gamePkg::colourGrass;
            [gamePkg::tileHazard:gamePkg::tileHazardTop]:
                return gamePkg::colourHazard;
            default:
                return gamePkg::colourUnknown;
        endcase
    endfunction

    logic outside;
    gamePkg::rgbColour nextColour;

    // Frame end pixel itself still counts as inside
    assign outside = (pixelPos.x > screenPkg::pixelsHoriz)
                  || (pixelPos.y > screenPkg::pixelsVert);

    always_comb
    begin
        if (!displayEnable)
            nextColour = gamePkg::colourBlank;
        else if (outside)
            nextColour = gamePkg::colourOutside;
        // Tank drawn over the map
        else if (inTank)
            nextColour = spriteColour;
        else
            nextColour = tileColour(pixelTile);
    end

    // One cycle from pixel to colour
    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
            pixelColour <= gamePkg::colourBlank;
        else
            pixelColour <= nextColour;
    end

endmodule

/* src/tankSprite.sv */
`timescale 1ns/1ps

module tankSprite (
    input  logic                  Master_Clock_In,
    input  logic                  rstN,
    input  screenPkg::screenPos   pixelPos,
    input  screenPkg::screenPos   tankPos,
    input  gamePkg::padButtons    buttons,
    output logic                  inTank,
    output gamePkg::rgbColour     spriteColour
);

    gamePkg::tankFacing facing;

    // Offsets from the tank origin
    logic [screenPkg::coordWidth-1:0] dx;
    logic [screenPkg::coordWidth-1:0] dy;
    // Across and along the barrel axis
    logic [screenPkg::coordWidth-1:0] u;
    logic [screenPkg::coordWidth-1:0] v;

    // Last pressed direction, priority up, down, left, right
    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
            facing <= gamePkg::faceUp;
        else if (buttons.up)
            facing <= gamePkg::faceUp;
        else if (buttons.down)
            facing <= gamePkg::faceDown;
        else if (buttons.left)
            facing <= gamePkg::faceLeft;
        else if (buttons.right)
            facing <= gamePkg::faceRight;
    end

    // Inclusive bounding box
    assign inTank = (pixelPos.x >= tankPos.x)
                 && (pixelPos.x <= tankPos.x + gamePkg::tankWidth)
                 && (pixelPos.y >= tankPos.y)
                 && (pixelPos.y <= tankPos.y + gamePkg::tankWidth);

    assign dx = pixelPos.x - tankPos.x;
    assign dy = pixelPos.y - tankPos.y;

    always_comb
    begin
        // Rotate into the up facing frame, barrel at small v
        case (facing)
            gamePkg::faceDown:
            begin
                u = dx;
                v = screenPkg::coordWidth'(gamePkg::tankWidth) - dy;
            end
            gamePkg::faceLeft:
            begin
                u = dy;
                v = dx;
            end
            gamePkg::faceRight:
            begin
                u = dy;
                v = screenPkg::coordWidth'(gamePkg::tankWidth) - dx;
            end
            default:
            begin
                u = dx;
                v = dy;
            end
        endcase

        // Barrel is a narrow strip from the front edge to the middle
        if ((u >= gamePkg::barrelLow) && (u <= gamePkg::barrelHigh)
                && (v <= gamePkg::barrelLength))
            spriteColour = gamePkg::colourBarrel;
        else
            spriteColour = gamePkg::colourBody;
    end

endmodule

/* src/tankMotion.sv */
`timescale 1ns/1ps

module tankMotion (
    input  logic                  Master_Clock_In,
    input  logic                  rstN,
    input  logic                  displayEnable,
    input  screenPkg::screenPos   pixelPos,
    input  gamePkg::padButtons    buttons,
    input  gamePkg::cornerTiles   corners,
    output screenPkg::screenPos   tankPos
);

    // Walls and bricks stop the tank, everything else is passable
    function automatic logic isBlocking(input gamePkg::tileCode code);
        return (code == gamePkg::tileWall) || (code == gamePkg::tileBrick);
    endfunction

    logic frameEnd;
    screenPkg::screenPos wrapped;
    screenPkg::screenPos nextPos;

    // Corner blocking flags
    logic hitTopLeft;
    logic hitTopRight;
    logic hitBottomLeft;
    logic hitBottomRight;

    ////////////////////////////////////////////////////////////
    // Frame end strobe
    ////////////////////////////////////////////////////////////

    // One update per frame at the point just past the last active pixel
    assign frameEnd = displayEnable
                   && (pixelPos.x == screenPkg::pixelsHoriz)
                   && (pixelPos.y == screenPkg::pixelsVert);

    ////////////////////////////////////////////////////////////
    // Next position
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Edge wrap comes first
        wrapped = gamePkg::wrapEdges(tankPos);
        nextPos = wrapped;

        // Corner codes already belong to the wrapped origin
        hitTopLeft = isBlocking(corners.topLeft);
        hitTopRight = isBlocking(corners.topRight);
        hitBottomLeft = isBlocking(corners.bottomLeft);
        hitBottomRight = isBlocking(corners.bottomRight);

        // Whole side inside a block, push straight back
        if (hitBottomLeft && hitBottomRight)
            nextPos.y = wrapped.y - 1'b1;
        else if (hitTopLeft && hitBottomLeft)
            nextPos.x = wrapped.x + 1'b1;
        else if (hitTopLeft && hitTopRight)
            nextPos.y = wrapped.y + 1'b1;
        else if (hitTopRight && hitBottomRight)
            nextPos.x = wrapped.x - 1'b1;
        // Single corner inside a block, push out diagonally
        else if (hitTopLeft)
        begin
            nextPos.y = wrapped.y + 1'b1;
            nextPos.x = wrapped.x + 1'b1;
        end
        else if (hitTopRight)
        begin
            nextPos.y = wrapped.y + 1'b1;
            nextPos.x = wrapped.x - 1'b1;
        end
        else if (hitBottomLeft)
        begin
            nextPos.y = wrapped.y - 1'b1;
            nextPos.x = wrapped.x + 1'b1;
        end
        else if (hitBottomRight)
        begin
            nextPos.y = wrapped.y - 1'b1;
            nextPos.x = wrapped.x - 1'b1;
        end
        // Free to move, one pixel per frame
        // Priority up, right, down, left
        else if (buttons.up)
            nextPos.y = wrapped.y - 1'b1;
        else if (buttons.right)
            nextPos.x = wrapped.x + 1'b1;
        else if (buttons.down)
            nextPos.y = wrapped.y + 1'b1;
        else if (buttons.left)
            nextPos.x = wrapped.x - 1'b1;
    end

    // Position register, held between strobes
    always_ff @(posedge Master_Clock_In)
    begin
        if (!rstN)
            tankPos <= gamePkg::tankStart;
        else if (frameEnd)
            tankPos <= nextPos;
    end

endmodule

/* src/tileMap.sv */
`timescale 1ns/1ps

module tileMap (
    input  screenPkg::screenPos   pixelPos,
    input  screenPkg::screenPos   tankPos,
    output gamePkg::tileCode      pixelTile,
    output gamePkg::cornerTiles   corners
);

    // Map code under any raster point
    function automatic gamePkg::tileCode tileAt(input screenPkg::screenPos point);
        int unsigned col;
        int unsigned row;
        // Tile index wraps modulo the grid size
        col = (point.x >> screenPkg::tileShift) % screenPkg::tileCols;
        row = (point.y >> screenPkg::tileShift) % screenPkg::tileRows;
        // Column 0 sits in the top nibble of the row word
        return gamePkg::mapRows[row][(screenPkg::tileCols - 1 - col) * 4 +: 4];
    endfunction

    // Origin after edge wrap, as the motion block sees it at frame end
    screenPkg::screenPos tankOrigin;
    // Far corner of the box
    screenPkg::screenPos tankFar;

    always_comb
    begin
        tankOrigin = gamePkg::wrapEdges(tankPos);
        tankFar.x = tankOrigin.x + screenPkg::coordWidth'(gamePkg::tankWidth);
        tankFar.y = tankOrigin.y + screenPkg::coordWidth'(gamePkg::tankWidth);
    end

    // Scan pixel
    assign pixelTile = tileAt(pixelPos);

    // Four corners of the tank box
    assign corners.topLeft = tileAt('{x: tankOrigin.x, y: tankOrigin.y});
    assign corners.topRight = tileAt('{x: tankFar.x, y: tankOrigin.y});
    assign corners.bottomLeft = tileAt('{x: tankOrigin.x, y: tankFar.y});
    assign corners.bottomRight = tileAt('{x: tankFar.x, y: tankFar.y});

endmodule

/* src/gamePkg.sv */
package gamePkg;

    ////////////////////////////////////////////////////////////
    // Map tiles
    ////////////////////////////////////////////////////////////

    typedef logic [3:0] tileCode;

    localparam tileCode tileOpen = 4'd0;
    localparam tileCode tileWall = 4'd1;
    localparam tileCode tileBrick = 4'd2;
    localparam tileCode tileGrass = 4'd3;
    // Hazard tiles span codes 4 through 7
    localparam tileCode tileHazard = 4'd4;
    localparam tileCode tileHazardTop = 4'd7;

    // One 80-bit word per tile row, column 0 in the top nibble
    // Brick frame of alternating brick and grass with an open border
    localparam logic [4*screenPkg::tileCols-1:0] mapRows [0:screenPkg::tileRows-1] = '{
        80'h0000_0000_0000_0000_0000,
        80'h0232_3223_2332_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2222_3223_2330,
        80'h0333_3333_3333_3333_3330,
        80'h0222_2232_2222_2322_2220,
        80'h0333_3333_3333_3333_3330,
        80'h0232_3223_2222_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2332_3223_2320,
        80'h0000_0000_0000_0000_0000
    };

    ////////////////////////////////////////////////////////////
    // Tank geometry
    ////////////////////////////////////////////////////////////

    // Box runs from the origin to origin plus tankWidth, both ends included
    localparam int tankWidth = 25;
    localparam screenPkg::screenPos tankStart = '{x: 10'd5, y: 10'd5};

    // Origin values at which the tank jumps to the opposite edge
    localparam int wrapLimitX = screenPkg::pixelsHoriz - tankWidth;
    localparam int wrapLimitY = screenPkg::pixelsVert - tankWidth;

    // Barrel strip in sprite coordinates, across u and along v
    localparam int barrelLow = 11;
    localparam int barrelHigh = 14;
    localparam int barrelLength = 12;

    ////////////////////////////////////////////////////////////
    // Colours
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbColour;

    localparam rgbColour colourOpen = '{red: 4'hF, green: 4'hF, blue: 4'hF};
    localparam rgbColour colourBrick = '{red: 4'hB, green: 4'h3, blue: 4'h1};
    localparam rgbColour colourGrass = '{red: 4'hF, green: 4'hF, blue: 4'h0};
    localparam rgbColour colourHazard = '{red: 4'hF, green: 4'h4, blue: 4'h4};
    localparam rgbColour colourUnknown = '{red: 4'h8, green: 4'h8, blue: 4'h8};
    localparam rgbColour colourOutside = '{red: 4'h2, green: 4'h2, blue: 4'h2};
    localparam rgbColour colourBlank = '{red: 4'h0, green: 4'h0, blue: 4'h0};
    localparam rgbColour colourBody = '{red: 4'h5, green: 4'h7, blue: 4'h2};
    localparam rgbColour colourBarrel = '{red: 4'h2, green: 4'h3, blue: 4'h1};

    ////////////////////////////////////////////////////////////
    // Controls
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } padButtons;

    typedef enum logic [1:0] {
        faceUp,
        faceDown,
        faceLeft,
        faceRight
    } tankFacing;

    // Map codes under the four corners of the tank box
    typedef struct packed {
        tileCode topLeft;
        tileCode topRight;
        tileCode bottomLeft;
        tileCode bottomRight;
    } cornerTiles;

    // Screen edge wrap of a tank origin
    // Shared by the motion update and the corner lookup
    function automatic screenPkg::screenPos wrapEdges(input screenPkg::screenPos pos);
        screenPkg::screenPos wrapped;
        wrapped = pos;
        // Top edge lands at the bottom, bottom edge lands at the top
        if (pos.y == 0)
            wrapped.y = screenPkg::coordWidth'(wrapLimitY - 1);
        else if (pos.y == wrapLimitY)
            wrapped.y = 1;
        // Same for left and right
        if (pos.x == 0)
            wrapped.x = screenPkg::coordWidth'(wrapLimitX - 1);
        else if (pos.x == wrapLimitX)
            wrapped.x = 1;
        return wrapped;
    endfunction

endpackage

/* src/screenPkg.sv */
package screenPkg;

    ////////////////////////////////////////////////////////////
    // Raster geometry
    ////////////////////////////////////////////////////////////

    // Active area of the 640x480 VGA scan
    localparam int pixelsHoriz = 640;
    localparam int pixelsVert = 480;

    // Every pixel and tank coordinate shares this width
    localparam int coordWidth = 10;

    ////////////////////////////////////////////////////////////
    // Tile grid
    ////////////////////////////////////////////////////////////

    // Tiles are 32 by 32 pixels
    localparam int tileShift = 5;

    // 20 tiles across, 15 tiles down
    localparam int tileCols = 20;
    localparam int tileRows = 15;

    // A point on the raster
    // Used for the scan pixel, the tank origin and the tank corners
    typedef struct packed {
        logic [coordWidth-1:0] x;
        logic [coordWidth-1:0] y;
    } screenPos;

endpackage
